//--- int_exec.f
isa_pkg.sv
pipe_pkg.sv
alu.sv
branch_unit.sv
ip.sv
int_exec.sv
tb_int_exec.sv

//--- run.sh
#!/bin/sh
# Build with Verilator from the project root, a compile error stops the script
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_int_exec -f int_exec.f -o sim_int_exec > build.log 2>&1 ||
    { cat build.log; echo "Build failed"; exit 1; }
# The simulation exits nonzero on $fatal, the log decides the result
./obj_dir/sim_int_exec > sim.log 2>&1 || true
cat sim.log
grep -q "Test FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "Test OK" sim.log || { echo "Simulation did not finish"; exit 1; }
exit 0

//--- tb_int_exec.sv
module tb_int_exec;

    timeunit 1ns;
    timeprecision 1ps;

    // Longest wait for a single handshake, in clock cycles
    localparam int wait_limit = 20;

    logic                clk;
    logic                rst;
    pipe_pkg::issue_op_t issue;
    logic                issue_valid;
    logic                issue_ready;
    isa_pkg::xlen_t      forwarding;
    pipe_pkg::wb_op_t    wb;
    logic                wb_valid;
    logic                wb_ready;
    pipe_pkg::redirect_t redirect;

    int_exec #(
        .handle_branch (1)
    ) dut_i (
        .clk         (clk),
        .rst         (rst),
        .issue       (issue),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready),
        .forwarding  (forwarding),
        .wb          (wb),
        .wb_valid    (wb_valid),
        .wb_ready    (wb_ready),
        .redirect    (redirect)
    );

    // The clock has a 4 ns period and stimulus changes on the falling edge
    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_word(input string name, input isa_pkg::xlen_t got,
            input isa_pkg::xlen_t exp);
        if (got !== exp) begin
            stop_run($sformatf("** Error at %0t: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_run($sformatf("** Error at %0t: %s is %b, expected %b", $time, name, got, exp));
        end
    endtask

    task automatic check_wb(input string name, input pipe_pkg::wb_op_t got,
            input pipe_pkg::wb_op_t exp);
        if (got !== exp) begin
            stop_run($sformatf("** Error at %0t: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_redirect(input string name, input pipe_pkg::redirect_t got,
            input pipe_pkg::redirect_t exp);
        if (got !== exp) begin
            stop_run($sformatf("** Error at %0t: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    // Holds at falling edges until the pipe can accept
    task automatic wait_issue_ready();
        int cycles;
        cycles = 0;
        while (issue_ready !== 1'b1) begin
            if (cycles == wait_limit) begin
                stop_run("issue_ready never went high, the pipe did not accept the instruction");
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    function automatic isa_pkg::xlen_t rand_word();
        return {$urandom, $urandom};
    endfunction

    // Reference result built from the ISA rules for each operation
    function automatic isa_pkg::xlen_t alu_model(input pipe_pkg::issue_op_t op);
        isa_pkg::xlen_t a;
        isa_pkg::xlen_t b;
        isa_pkg::xlen_t r;
        int unsigned sh;
        a = op.operand1;
        b = op.operand2;
        sh = {26'd0, b[5:0]};
        case (op.op)
            isa_pkg::op_add: r = op.option ? a - b : a + b;
            isa_pkg::op_sll: r = a << sh;
            isa_pkg::op_slt: r = {63'd0, $signed(a) < $signed(b)};
            isa_pkg::op_sltu: r = {63'd0, a < b};
            isa_pkg::op_xor: r = a ^ b;
            isa_pkg::op_srl: begin
                r = a >> sh;
                // An arithmetic shift refills the vacated top bits with the sign
                if (op.option && a[63]) begin
                    r = r | ~({64{1'b1}} >> sh);
                end
            end
            isa_pkg::op_or: r = a | b;
            isa_pkg::op_and: r = a & b;
            isa_pkg::op_eq: r = {63'd0, a == b};
            default: r = '0;
        endcase
        if (op.truncate) begin
            r = {{32{r[31]}}, r[31:0]};
        end
        return r;
    endfunction

    function automatic isa_pkg::xlen_t target_model(input pipe_pkg::issue_op_t op);
        isa_pkg::xlen_t sum;
        sum = op.br_base + {{43{op.br_offset[20]}}, op.br_offset};
        sum[0] = 1'b0;
        return sum;
    endfunction

    function automatic logic mispredict_model(input pipe_pkg::issue_op_t op);
        logic taken;
        taken = 1'b1;
        if (op.br_type == isa_pkg::bt_none) begin
            return 1'b0;
        end
        if (op.br_type == isa_pkg::bt_bcond) begin
            if (op.op == isa_pkg::op_eq) begin
                taken = op.operand1 == op.operand2;
            end else begin
                taken = $signed(op.operand1) < $signed(op.operand2);
            end
            taken = taken ^ op.br_neg;
        end
        return (taken != op.bp) || (taken && target_model(op) != op.bt);
    endfunction

    function automatic pipe_pkg::wb_op_t expected_wb(input pipe_pkg::issue_op_t op);
        pipe_pkg::wb_op_t w;
        w.dst = op.dst;
        w.result = alu_model(op);
        w.pc = op.pc;
        w.wb_en = op.wb_en;
        return w;
    endfunction

    // Plain ALU instruction with random pc, destination and operands
    function automatic pipe_pkg::issue_op_t plain_op(input isa_pkg::alu_op_e op,
            input logic option, input logic truncate);
        pipe_pkg::issue_op_t i;
        i = '0;
        i.pc = rand_word();
        i.pc[1:0] = 2'b00;
        i.dst = isa_pkg::reg_idx_t'($urandom);
        i.wb_en = 1'b1;
        i.op = op;
        i.option = option;
        i.truncate = truncate;
        i.br_type = isa_pkg::bt_none;
        i.operand1 = rand_word();
        i.operand2 = rand_word();
        return i;
    endfunction

    // The instruction accepted during a redirect must vanish without a redirect of its own
    task automatic check_squash();
        pipe_pkg::issue_op_t o;
        o = plain_op(isa_pkg::op_add, 1'b0, 1'b0);
        o.br_type = isa_pkg::bt_jal;
        o.br_base = o.pc;
        o.br_offset = isa_pkg::br_offset_t'($urandom);
        // Predicted not taken, so this jump would redirect if it were not squashed
        o.bp = 1'b0;
        issue = o;
        issue_valid = 1'b1;
        @(negedge clk);
        issue_valid = 1'b0;
        check_flag("wb_valid", wb_valid, 1'b0);
        check_flag("redirect.pc_override", redirect.pc_override, 1'b0);
    endtask

    // Issue one instruction and check forwarding at once and wb and redirect a cycle later
    task automatic run_one(input pipe_pkg::issue_op_t op);
        pipe_pkg::wb_op_t exp_wb;
        pipe_pkg::redirect_t exp_redirect;
        logic exp_override;
        exp_wb = expected_wb(op);
        exp_override = mispredict_model(op);
        exp_redirect.pc_override = 1'b1;
        exp_redirect.new_pc = target_model(op);
        issue = op;
        issue_valid = 1'b1;
        wait_issue_ready();
        #1;
        check_word("forwarding", forwarding, exp_wb.result);
        @(negedge clk);
        issue_valid = 1'b0;
        check_flag("wb_valid", wb_valid, 1'b1);
        check_wb("wb", wb, exp_wb);
        check_flag("redirect.pc_override", redirect.pc_override, exp_override);
        if (exp_override) begin
            check_redirect("redirect", redirect, exp_redirect);
            check_squash();
        end
    endtask

    task automatic test_reset();
        rst = 1'b1;
        repeat (8) begin
            @(negedge clk);
            check_flag("wb_valid", wb_valid, 1'b0);
            check_flag("redirect.pc_override", redirect.pc_override, 1'b0);
        end
        rst = 1'b0;
        @(negedge clk);
        check_flag("wb_valid", wb_valid, 1'b0);
        check_flag("redirect.pc_override", redirect.pc_override, 1'b0);
    endtask

    task automatic test_alu();
        isa_pkg::alu_op_e ops[9];
        pipe_pkg::issue_op_t o;
        ops = '{isa_pkg::op_add, isa_pkg::op_sll, isa_pkg::op_slt, isa_pkg::op_sltu,
                isa_pkg::op_xor, isa_pkg::op_srl, isa_pkg::op_or, isa_pkg::op_and,
                isa_pkg::op_eq};
        foreach (ops[k]) begin
            for (int opt = 0; opt < 2; opt++) begin
                for (int tr = 0; tr < 2; tr++) begin
                    for (int rep = 0; rep < 2; rep++) begin
                        o = plain_op(ops[k], opt[0], tr[0]);
                        // Equal operands exercise eq and the compare boundary
                        if (rep == 1) begin
                            o.operand2 = o.operand1;
                        end
                        run_one(o);
                    end
                end
            end
        end
    endtask

    // The link value is pc plus 4 and a wrong target guess must redirect
    task automatic test_jumps();
        pipe_pkg::issue_op_t o;
        for (int kind = 0; kind < 2; kind++) begin
            for (int good = 0; good < 2; good++) begin
                o = plain_op(isa_pkg::op_add, 1'b0, 1'b0);
                o.br_type = (kind == 0) ? isa_pkg::bt_jal : isa_pkg::bt_jalr;
                o.operand1 = o.pc;
                o.operand2 = 64'd4;
                o.br_base = (kind == 0) ? o.pc : rand_word();
                o.br_offset = isa_pkg::br_offset_t'($urandom);
                o.bp = 1'b1;
                o.bt = target_model(o);
                if (good == 0) begin
                    o.bt = o.bt + 64'd8;
                end
                run_one(o);
            end
        end
    endtask

    task automatic test_branches();
        pipe_pkg::issue_op_t o;
        for (int cmp = 0; cmp < 2; cmp++) begin
            for (int neg = 0; neg < 2; neg++) begin
                for (int pred = 0; pred < 2; pred++) begin
                    for (int rep = 0; rep < 3; rep++) begin
                        o = plain_op((cmp == 0) ? isa_pkg::op_eq : isa_pkg::op_slt, 1'b0, 1'b0);
                        o.wb_en = 1'b0;
                        o.br_type = isa_pkg::bt_bcond;
                        o.br_neg = neg[0];
                        o.bp = pred[0];
                        if (rep == 0) begin
                            o.operand2 = o.operand1;
                        end
                        o.br_base = o.pc;
                        o.br_offset = isa_pkg::br_offset_t'($urandom);
                        o.br_offset[0] = 1'b0;
                        o.bt = target_model(o);
                        // Wrong target guess only matters on a taken branch
                        if (rep == 2) begin
                            o.bt = o.bt ^ 64'h10;
                        end
                        run_one(o);
                    end
                end
            end
        end
    endtask

    task automatic test_backpressure();
        pipe_pkg::issue_op_t first;
        pipe_pkg::issue_op_t second;
        first = plain_op(isa_pkg::op_xor, 1'b0, 1'b0);
        second = plain_op(isa_pkg::op_add, 1'b1, 1'b0);
        issue = first;
        issue_valid = 1'b1;
        wait_issue_ready();
        @(negedge clk);
        // Writeback stalls with the first result in the register
        wb_ready = 1'b0;
        issue = second;
        #1;
        check_flag("issue_ready", issue_ready, 1'b0);
        check_flag("wb_valid", wb_valid, 1'b1);
        check_wb("wb", wb, expected_wb(first));
        repeat (5) begin
            @(negedge clk);
            check_flag("issue_ready", issue_ready, 1'b0);
            check_flag("wb_valid", wb_valid, 1'b1);
            check_wb("wb", wb, expected_wb(first));
        end
        wb_ready = 1'b1;
        #1;
        wait_issue_ready();
        @(negedge clk);
        issue_valid = 1'b0;
        check_flag("wb_valid", wb_valid, 1'b1);
        check_wb("wb", wb, expected_wb(second));
        // Second result leaves on this edge and is not repeated
        @(negedge clk);
        check_flag("wb_valid", wb_valid, 1'b0);
    endtask

    initial begin
        void'($urandom(89619));
        rst = 1'b1;
        issue = '0;
        issue_valid = 1'b0;
        wb_ready = 1'b1;
        test_reset();
        test_alu();
        test_jumps();
        test_branches();
        test_backpressure();
        $display("Test OK");
        $finish;
    end

endmodule

//--- int_exec.sv
module int_exec #(
    parameter int handle_branch = 1
) (
    input  logic                clk,
    input  logic                rst,
    input  pipe_pkg::issue_op_t issue,
    input  logic                issue_valid,
    output logic                issue_ready,
    output isa_pkg::xlen_t      forwarding,
    output pipe_pkg::wb_op_t    wb,
    output logic                wb_valid,
    input  logic                wb_ready,
    output pipe_pkg::redirect_t redirect
);

    // ALU result after truncation, also the forwarding value
    isa_pkg::xlen_t alu_result;

    // Raw compare outcome for the branch unit
    logic alu_cond;

    // Branch resolution for the control module
    isa_pkg::xlen_t target;
    logic mispredict;

    alu alu_i (
        .op       (issue.op),
        .option   (issue.option),
        .truncate (issue.truncate),
        .operand1 (issue.operand1),
        .operand2 (issue.operand2),
        .result   (alu_result),
        .cond     (alu_cond)
    );

    generate
        if (handle_branch == 1) begin : g_branch
            branch_unit branch_unit_i (
                .issue      (issue),
                .cond       (alu_cond),
                .target     (target),
                .mispredict (mispredict)
            );
        end else begin : g_no_branch
            // Jumps are then resolved before this pipe
            assign target     = '0;
            assign mispredict = 1'b0;
        end
    endgenerate

    // Issue sees the result in the same cycle for back-to-back dependents
    assign forwarding = alu_result;

    ip #(
        .handle_branch (handle_branch)
    ) ip_i (
        .clk         (clk),
        .rst         (rst),
        .issue       (issue),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready),
        .alu_result  (alu_result),
        .target      (target),
        .mispredict  (mispredict),
        .wb          (wb),
        .wb_valid    (wb_valid),
        .wb_ready    (wb_ready),
        .redirect    (redirect)
    );

endmodule

//--- ip.sv
module ip #(
    parameter int handle_branch = 1
) (
    input  logic                clk,
    input  logic                rst,
    input  pipe_pkg::issue_op_t issue,
    input  logic                issue_valid,
    output logic                issue_ready,
    input  isa_pkg::xlen_t      alu_result,
    input  isa_pkg::xlen_t      target,
    input  logic                mispredict,
    output pipe_pkg::wb_op_t    wb,
    output logic                wb_valid,
    input  logic                wb_ready,
    output pipe_pkg::redirect_t redirect
);

    // Instruction taken from issue on this edge
    logic accept;

    // Instruction accepted while fetch is being redirected is on the wrong path
    logic squash;

    // No skid buffer, so the stage only moves when writeback can take the result
    assign issue_ready = wb_ready;

    assign accept = issue_valid && issue_ready;
    assign squash = redirect.pc_override;

    // Valid bit of the writeback register
    // With wb_ready high the old result leaves and the new one, if any, enters
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid <= 1'b0;
        end else if (issue_ready) begin
            wb_valid <= issue_valid && !squash;
        end
    end

    // Payload follows the accepted instruction and holds under back-pressure
    always_ff @(posedge clk) begin
        if (accept) begin
            wb.dst    <= issue.dst;
            wb.result <= alu_result;
            wb.pc     <= issue.pc;
            wb.wb_en  <= issue.wb_en;
        end
    end

    generate
        if (handle_branch == 1) begin : g_redirect
            // A squashed branch must not redirect again
            always_ff @(posedge clk) begin
                if (rst) begin
                    redirect.pc_override <= 1'b0;
                end else begin
                    redirect.pc_override <= accept && mispredict && !squash;
                end
            end

            // Only meaningful while pc_override is high
            always_ff @(posedge clk) begin
                redirect.new_pc <= target;
            end
        end else begin : g_no_redirect
            // Without branch support the front end resolves everything
            assign redirect = '0;
        end
    endgenerate

    // Fetch needs a cycle to restart, so the redirect pulse is a single cycle
    a_override_pulse : assert property (
        @(posedge clk) disable iff (rst)
        redirect.pc_override |=> !redirect.pc_override
    );

    // Writeback must see the same result until it takes it
    a_wb_hold : assert property (
        @(posedge clk) disable iff (rst)
        (wb_valid && !wb_ready) |=> (wb_valid && $stable(wb))
    );

endmodule

//--- branch_unit.sv
module branch_unit (
    input  pipe_pkg::issue_op_t issue,
    input  logic                cond,
    output isa_pkg::xlen_t      target,
    output logic                mispredict
);

    // Immediate widened to a full machine word
    isa_pkg::xlen_t offset_ext;

    // Sum before the low bit is dropped
    isa_pkg::xlen_t target_sum;

    // Resolved direction of the instruction
    logic taken;

    // Front end guessed the direction or the target wrong
    logic dir_wrong;
    logic tgt_wrong;

    assign offset_ext = {
        {(isa_pkg::xlen - isa_pkg::br_offset_w){issue.br_offset[isa_pkg::br_offset_w-1]}},
        issue.br_offset
    };

    assign target_sum = issue.br_base + offset_ext;

    // Bit 0 is cleared as jalr requires, harmless for the other kinds
    assign target = {target_sum[isa_pkg::xlen-1:1], 1'b0};

    always_comb begin
        taken = 1'b0;
        case (issue.br_type)
            isa_pkg::bt_jal: begin
                taken = 1'b1;
            end
            isa_pkg::bt_jalr: begin
                taken = 1'b1;
            end
            isa_pkg::bt_bcond: begin
                // bne, bge and bgeu reuse eq, slt and sltu with the outcome inverted
                taken = issue.br_neg ? !cond : cond;
            end
            default: begin
                taken = 1'b0;
            end
        endcase
    end

    assign dir_wrong = taken != issue.bp;

    // A target guess only matters when the transfer is taken
    assign tgt_wrong = taken && (target != issue.bt);

    // Plain ALU instructions never redirect
    assign mispredict = (issue.br_type != isa_pkg::bt_none) && (dir_wrong || tgt_wrong);

endmodule

//--- alu.sv
module alu (
    input  isa_pkg::alu_op_e op,
    input  logic             option,
    input  logic             truncate,
    input  isa_pkg::xlen_t   operand1,
    input  isa_pkg::xlen_t   operand2,
    output isa_pkg::xlen_t   result,
    output logic             cond
);

    // Shift amount is the low bits of the second operand
    logic [isa_pkg::shamt_w-1:0] shamt;

    // Full-width result before any 32-bit truncation
    isa_pkg::xlen_t raw;

    // Comparison outcomes, zero-extended into the result for slt, sltu and eq
    logic lt_signed;
    logic lt_unsigned;
    logic equal;

    assign shamt = operand2[isa_pkg::shamt_w-1:0];

    assign lt_signed   = $signed(operand1) < $signed(operand2);
    assign lt_unsigned = operand1 < operand2;
    assign equal       = operand1 == operand2;

    always_comb begin
        raw = '0;
        case (op)
            isa_pkg::op_add: begin
                // Option turns add into subtract
                if (option) begin
                    raw = operand1 - operand2;
                end else begin
                    raw = operand1 + operand2;
                end
            end
            isa_pkg::op_sll: begin
                raw = operand1 << shamt;
            end
            isa_pkg::op_slt: begin
                raw = {{(isa_pkg::xlen-1){1'b0}}, lt_signed};
            end
            isa_pkg::op_sltu: begin
                raw = {{(isa_pkg::xlen-1){1'b0}}, lt_unsigned};
            end
            isa_pkg::op_xor: begin
                raw = operand1 ^ operand2;
            end
            isa_pkg::op_srl: begin
                // Option selects the arithmetic shift
                if (option) begin
                    raw = isa_pkg::xlen_t'($signed(operand1) >>> shamt);
                end else begin
                    raw = operand1 >> shamt;
                end
            end
            isa_pkg::op_or: begin
                raw = operand1 | operand2;
            end
            isa_pkg::op_and: begin
                raw = operand1 & operand2;
            end
            isa_pkg::op_eq: begin
                raw = {{(isa_pkg::xlen-1){1'b0}}, equal};
            end
            default: begin
                raw = '0;
            end
        endcase
    end

    // W-type instructions keep the low word and sign-extend it
    assign result = truncate ? {{32{raw[31]}}, raw[31:0]} : raw;

    // The branch unit reads the compare outcome before truncation
    assign cond = raw[0];

endmodule

//--- pipe_pkg.sv
package pipe_pkg;

    // One decoded instruction as handed over by issue
    typedef struct packed {
        isa_pkg::xlen_t      pc;
        isa_pkg::reg_idx_t   dst;
        logic                wb_en;
        // ALU control
        isa_pkg::alu_op_e    op;
        logic                option;
        logic                truncate;
        // Branch control, br_base is pc for jal and bcond, rs1 for jalr
        isa_pkg::br_type_e   br_type;
        logic                br_neg;
        isa_pkg::xlen_t      br_base;
        isa_pkg::br_offset_t br_offset;
        // Source operands, already read or forwarded by issue
        isa_pkg::xlen_t      operand1;
        isa_pkg::xlen_t      operand2;
        // Prediction made by the front end
        logic                bp;
        isa_pkg::xlen_t      bt;
    } issue_op_t;

    // Result handed to writeback
    typedef struct packed {
        isa_pkg::reg_idx_t dst;
        isa_pkg::xlen_t    result;
        isa_pkg::xlen_t    pc;
        logic              wb_en;
    } wb_op_t;

    // Fetch restarts at new_pc in the cycle pc_override is high
    typedef struct packed {
        logic           pc_override;
        isa_pkg::xlen_t new_pc;
    } redirect_t;

endpackage

//--- isa_pkg.sv
package isa_pkg;

    // Word width of the machine, fixed by the 64-bit ISA
    localparam int xlen = 64;

    // Number of bits needed to name one of the 32 integer registers
    localparam int reg_idx_w = 5;

    // Branch and jump immediates are at most 21 bits wide (JAL format)
    localparam int br_offset_w = 21;

    // Shift amounts come from the low bits of the second operand
    localparam int shamt_w = 6;

    typedef logic [xlen-1:0] xlen_t;
    typedef logic [reg_idx_w-1:0] reg_idx_t;
    typedef logic signed [br_offset_w-1:0] br_offset_t;

    // ALU operations, encoded like funct3 with op_eq appended
    // The option bit selects sub instead of add and sra instead of srl
    typedef enum logic [3:0] {
        op_add  = 4'd0,
        op_sll  = 4'd1,
        op_slt  = 4'd2,
        op_sltu = 4'd3,
        op_xor  = 4'd4,
        op_srl  = 4'd5,
        op_or   = 4'd6,
        op_and  = 4'd7,
        op_eq   = 4'd8
    } alu_op_e;

    // Kind of control transfer carried by an instruction
    typedef enum logic [1:0] {
        bt_none  = 2'd0,
        bt_jal   = 2'd1,
        bt_jalr  = 2'd2,
        bt_bcond = 2'd3
    } br_type_e;

endpackage
